//--- design/sample_pkg.sv
package sample_pkg;

    ////////////////////////////////
    // Sample side
    ////////////////////////////////

    // One waveform sample, also used for the amplitude setting.
    typedef logic [7:0] sample_t;

    // Level match flags for the current sample.
    typedef struct packed {
        logic at_high; // Within tolerance of amplitude.
        logic at_low;  // Within tolerance of 256 - amplitude.
    } level_flags_t;

endpackage

//--- design/result_pkg.sv
package result_pkg;

    ////////////////////////////////
    // Count side
    ////////////////////////////////

    // Field width of the count record, the top sets the used width at or below it.
    localparam int CNT_W_MAX = 12;

    typedef struct packed {
        logic [CNT_W_MAX-1:0] high_cnt;  // Samples in the high phase.
        logic [CNT_W_MAX-1:0] total_cnt; // Samples in the whole period.
    } count_rec_t;

    ////////////////////////////////
    // Percentage side
    ////////////////////////////////

    typedef logic [6:0] pct_t; // 0 to 100.

    typedef struct packed {
        pct_t duty;
        logic valid;
    } duty_rec_t;

endpackage

//--- design/level_classifier.sv
`timescale 1ns/1ps

module level_classifier #(
    parameter int TOLERANCE = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sample_pkg::sample_t      wave_in,
    input  sample_pkg::sample_t      amplitude,
    output sample_pkg::level_flags_t flags
);
    import sample_pkg::*;

    sample_t    amp_q;
    logic [8:0] wave_w;
    logic [8:0] high_lvl;
    logic [8:0] low_lvl;
    logic [8:0] diff_high;
    logic [8:0] diff_low;

    // Amplitude is sampled once per clock.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            amp_q <= '0;
        end else begin
            amp_q <= amplitude;
        end
    end

    // Nine bits so neither level nor difference can wrap.
    assign wave_w   = {1'b0, wave_in};
    assign high_lvl = {1'b0, amp_q};
    assign low_lvl  = 9'd256 - {1'b0, amp_q};

    assign diff_high = (wave_w >= high_lvl) ? wave_w - high_lvl : high_lvl - wave_w;
    assign diff_low  = (wave_w >= low_lvl) ? wave_w - low_lvl : low_lvl - wave_w;

    assign flags.at_high = (diff_high <= 9'(TOLERANCE));
    assign flags.at_low  = (diff_low <= 9'(TOLERANCE));

endmodule

//--- design/cycle_counter.sv
`timescale 1ns/1ps

module cycle_counter #(
    parameter int CNT_WIDTH = 10
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  sample_pkg::level_flags_t flags,
    output result_pkg::count_rec_t   counts,
    output logic                     count_done
);
    import result_pkg::*;

    typedef enum logic [1:0] {
        ST_ARM,
        ST_WAIT_HIGH,
        ST_HIGH,
        ST_LOW
    } state_t;

    localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;

    state_t               state;
    state_t               state_nx;
    logic [CNT_WIDTH-1:0] high_cnt;
    logic [CNT_WIDTH-1:0] total_cnt;
    logic                 total_full;
    logic                 start;
    logic                 period_end;
    logic                 add_high;
    logic                 add_total;

    assign total_full = (total_cnt == CNT_MAX);

    //////////////////////////////
    // Period FSM
    //////////////////////////////

    always_comb begin
        state_nx   = state;
        start      = 1'b0;
        period_end = 1'b0;
        add_high   = 1'b0;
        add_total  = 1'b0;
        case (state)
            ST_ARM: begin
                if (flags.at_low) state_nx = ST_WAIT_HIGH;
            end
            ST_WAIT_HIGH: begin
                if (flags.at_high) begin
                    state_nx = ST_HIGH;
                    start    = 1'b1;
                end
            end
            ST_HIGH: begin
                if (total_full) begin
                    state_nx = ST_ARM; // Too long, drop and re-arm.
                end else begin
                    add_total = 1'b1;
                    if (flags.at_low) state_nx = ST_LOW;
                    else add_high = 1'b1; // In-between samples extend the high phase.
                end
            end
            default: begin // ST_LOW
                if (flags.at_high) begin
                    state_nx   = ST_HIGH;
                    period_end = 1'b1; // This sample opens the next period.
                end else if (total_full) begin
                    state_nx = ST_ARM;
                end else begin
                    add_total = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_ARM;
            count_done <= 1'b0;
        end else begin
            state      <= state_nx;
            count_done <= period_end;
        end
    end

    //////////////////////////////
    // Counters and record
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (start || period_end) begin
            high_cnt  <= CNT_WIDTH'(1);
            total_cnt <= CNT_WIDTH'(1);
        end else begin
            if (add_high) high_cnt <= high_cnt + 1'b1;
            if (add_total) total_cnt <= total_cnt + 1'b1;
        end
        if (period_end) begin
            counts.high_cnt  <= CNT_W_MAX'(high_cnt);
            counts.total_cnt <= CNT_W_MAX'(total_cnt);
        end
    end

endmodule

//--- design/duty_divider.sv
`timescale 1ns/1ps

module duty_divider #(
    parameter int CNT_WIDTH = 10
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  result_pkg::count_rec_t counts,
    input  logic                   count_done,
    output result_pkg::pct_t       pct,
    output logic                   pct_done
);
    import result_pkg::*;

    // 100 times the largest count fits in seven more bits.
    localparam int DIV_W = CNT_WIDTH + 7;

    logic [DIV_W-1:0] rem;  // Running remainder.
    logic [DIV_W-1:0] den;  // Divisor aligned to the current quotient bit.
    pct_t             quo;
    logic [2:0]       step;
    logic             busy;
    logic             accept;
    logic             fits;

    assign accept = count_done && !busy; // Strobes while busy are dropped.
    assign fits   = (rem >= den);

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step     <= '0;
            pct_done <= 1'b0;
        end else begin
            pct_done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == 3'd6) begin
                    busy     <= 1'b0;
                    pct_done <= 1'b1; // Last quotient bit is in.
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Restoring division
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            rem <= DIV_W'(counts.high_cnt[CNT_WIDTH-1:0]) * DIV_W'(100);
            den <= DIV_W'(counts.total_cnt[CNT_WIDTH-1:0]) << 6;
            quo <= '0;
        end else if (busy) begin
            if (fits) rem <= rem - den;
            den <= den >> 1;
            quo <= {quo[5:0], fits}; // Bit 6 first.
        end
    end

    assign pct = quo;

endmodule

//--- design/result_confirm.sv
`timescale 1ns/1ps

module result_confirm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  result_pkg::pct_t      pct,
    input  logic                  pct_done,
    output result_pkg::duty_rec_t result
);
    import result_pkg::*;

    pct_t prev_pct;  // Last raw percentage.
    logic have_prev;
    logic agree;

    assign agree = have_prev && (pct == prev_pct);

    // Publish only when two periods in a row agree.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result    <= '0;
            have_prev <= 1'b0;
        end else if (pct_done) begin
            have_prev <= 1'b1;
            if (agree) begin
                result.duty  <= pct;
                result.valid <= 1'b1; // Stays set until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pct_done) prev_pct <= pct;
    end

endmodule

//--- design/duty_meter_top.sv
`timescale 1ns/1ps

module duty_meter_top #(
    parameter int TOLERANCE = 4,
    parameter int CNT_WIDTH = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    input  sample_pkg::sample_t wave_in,
    input  sample_pkg::sample_t amplitude,
    output result_pkg::pct_t    duty,
    output logic                duty_valid
);
    import sample_pkg::*;
    import result_pkg::*;

    level_flags_t flags;
    count_rec_t   counts;
    logic         count_done;
    pct_t         pct;
    logic         pct_done;
    duty_rec_t    result;

    level_classifier #(
        .TOLERANCE (TOLERANCE)
    ) u_classifier (
        .clk       (clk),
        .rst_n     (rst_n),
        .wave_in   (wave_in),
        .amplitude (amplitude),
        .flags     (flags)
    );

    cycle_counter #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .flags      (flags),
        .counts     (counts),
        .count_done (count_done)
    );

    duty_divider #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_divider (
        .clk        (clk),
        .rst_n      (rst_n),
        .counts     (counts),
        .count_done (count_done),
        .pct        (pct),
        .pct_done   (pct_done)
    );

    result_confirm u_confirm (
        .clk      (clk),
        .rst_n    (rst_n),
        .pct      (pct),
        .pct_done (pct_done),
        .result   (result)
    );

    assign duty       = result.duty;
    assign duty_valid = result.valid;

endmodule

//--- bench/square_wave_gen.sv
`timescale 1ns/1ps

module square_wave_gen #(
    parameter int NOISE_MAX = 4
) (
    input  logic                clk,
    input  int                  high_len,
    input  int                  low_len,
    input  sample_pkg::sample_t amp_set,
    input  logic                noise_set,
    input  int                  tag_set,
    output sample_pkg::sample_t wave,
    output sample_pkg::sample_t amplitude,
    output logic                period_start,
    output int                  tag
);
    int   seed = 39151;
    int   pos = 0;
    int   cur_h = 0;
    int   cur_l = 0;
    int   cur_tag = 0;
    logic cur_noise = 1'b0;
    int   level;
    int   offset;

    initial begin
        wave         = 8'd128; // Mid scale until the first settings load.
        amplitude    = 8'd128;
        period_start = 1'b0;
        tag          = 0;
    end

    // One sample per falling edge, new settings only at a period boundary.
    always @(negedge clk) begin
        level  = (pos < cur_h) ? amplitude : 256 - amplitude;
        offset = cur_noise ? $random(seed) % (NOISE_MAX + 1) : 0;
        wave         <= 8'(level + offset);
        period_start <= (pos == 0);
        tag          <= cur_tag;
        pos = pos + 1;
        if (pos >= cur_h + cur_l) begin
            pos       = 0;
            cur_h     = high_len;
            cur_l     = low_len;
            cur_noise = noise_set;
            cur_tag   = tag_set;
            amplitude <= amp_set; // One sample ahead, the DUT registers it.
        end
    end

endmodule

//--- bench/tb_duty_meter.sv
`timescale 1ns/1ps

module tb_duty_meter;
    import sample_pkg::*;
    import result_pkg::*;

    localparam int TOLERANCE    = 4;
    localparam int RESET_CYCLES = 10;
    localparam int SEGMENTS     = 12;
    localparam int MAX_PERIOD   = 1023;

    logic    clk = 1'b0;
    logic    rst_n = 1'b0;
    sample_t wave;
    sample_t amplitude;
    pct_t    duty;
    logic    duty_valid;

    // Generator settings, changed on rising edges.
    int      set_h = 0;
    int      set_l = 0;
    sample_t set_amp = 8'd200;
    logic    set_noise = 1'b0;
    int      set_tag = 0;
    logic    period_start;
    int      gen_tag;

    int      seg_h [SEGMENTS];
    int      seg_l [SEGMENTS];
    sample_t seg_amp [SEGMENTS];
    logic    seg_noise [SEGMENTS];
    int      seed = 39151;
    int      limit = RESET_CYCLES + 20;
    int      cycles = 0;
    int      released = 0;
    logic    valid_seen = 1'b0;
    int      cur_duty = 0;
    logic    have_duty = 1'b0;

    duty_meter_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .wave_in    (wave),
        .amplitude  (amplitude),
        .duty       (duty),
        .duty_valid (duty_valid)
    );

    square_wave_gen #(
        .NOISE_MAX (TOLERANCE)
    ) u_gen (
        .clk          (clk),
        .high_len     (set_h),
        .low_len      (set_l),
        .amp_set      (set_amp),
        .noise_set    (set_noise),
        .tag_set      (set_tag),
        .wave         (wave),
        .amplitude    (amplitude),
        .period_start (period_start),
        .tag          (gen_tag)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Reference and checks
    //////////////////////////////

    function automatic int expected_duty(input int h, input int l);
        return (100 * h) / (h + l); // Floor of the high share in percent.
    endfunction

    task automatic stop_run(input string msg);
        $display("** FAIL **");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else stop_run($sformatf("mismatch at time %0t: %s expected %0d, actual %0d",
                                $time, name, expected, actual));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            stop_run($sformatf("timeout: run still busy after %0d cycles", cycles));
        end else if (!rst_n) begin
            released   <= 0;
            valid_seen <= 1'b0;
            if (cycles > 0) begin // Outputs are unknown before the first edge.
                check_value("duty_valid", 0, duty_valid);
                check_value("duty", 0, duty);
            end
        end else begin
            released <= released + 1;
            if (duty_valid) valid_seen <= 1'b1;
            if (valid_seen) check_value("duty_valid", 1, duty_valid); // Sticky.
            // Arming, two full periods and the result pipeline come first.
            if (released <= 2 * (seg_h[0] + seg_l[0]) + 10) begin
                check_value("duty_valid", 0, duty_valid);
            end
            if (!duty_valid) check_value("duty", 0, duty);
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic add_segment(input int idx, input int h, input int l, input sample_t amp,
                               input logic noise);
        seg_h[idx]     = h;
        seg_l[idx]     = l;
        seg_amp[idx]   = amp;
        seg_noise[idx] = noise;
        limit          = limit + 4 * (h + l) + 20; // Start wait plus three periods.
    endtask

    task automatic run_segment(input int idx);
        int period;
        int new_duty;
        int tag;
        int k;
        period   = seg_h[idx] + seg_l[idx];
        new_duty = (period > MAX_PERIOD) ? cur_duty : expected_duty(seg_h[idx], seg_l[idx]);
        tag      = set_tag + 1;
        @(posedge clk);
        set_h     <= seg_h[idx];
        set_l     <= seg_l[idx];
        set_amp   <= seg_amp[idx];
        set_noise <= seg_noise[idx];
        set_tag   <= tag;
        do begin
            @(posedge clk);
        end while (!(period_start && gen_tag == tag)); // First sample of the new wave.
        for (k = 0; k <= 3 * period + 10; k++) begin
            if (k > 0) @(posedge clk);
            if (k >= 3 * period) begin
                check_value("duty_valid", 1, duty_valid);
                check_value("duty", new_duty, duty);
            end else if (have_duty) begin
                check_value("duty_valid", 1, duty_valid);
                assert (duty == cur_duty || duty == new_duty)
                else stop_run($sformatf(
                    "mismatch at time %0t: duty expected %0d or %0d, actual %0d",
                    $time, cur_duty, new_duty, duty));
            end
        end
        cur_duty  = new_duty;
        have_duty = 1'b1;
    endtask

    initial begin
        int i;
        add_segment(0, 5, 5, 8'd200, 1'b0);
        add_segment(1, 3, 97, 8'd200, 1'b0);
        add_segment(2, 40, 10, 8'd200, 1'b0);
        add_segment(3, 30, 70, 8'd200, 1'b1); // Noisy levels.
        add_segment(4, 17, 23, 8'd160, 1'b1);
        add_segment(5, 61, 39, 8'd250, 1'b1);
        add_segment(6, 600, 600, 8'd200, 1'b0); // Period beyond the count range.
        add_segment(7, 25, 75, 8'd200, 1'b0);
        for (i = 8; i < SEGMENTS; i++) begin
            add_segment(i, 5 + $unsigned($random(seed)) % 146,
                        5 + $unsigned($random(seed)) % 146, 8'd200, 1'b0);
        end
        set_h     = seg_h[0];
        set_l     = seg_l[0];
        set_amp   = seg_amp[0];
        set_noise = seg_noise[0];
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (i = 0; i < SEGMENTS; i++) begin
            run_segment(i);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- compile.f
design/sample_pkg.sv
design/result_pkg.sv
design/level_classifier.sv
design/cycle_counter.sv
design/duty_divider.sv
design/result_confirm.sv
design/duty_meter_top.sv
bench/square_wave_gen.sv
bench/tb_duty_meter.sv
